//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_read_top
RTL_TOP   := mem_read_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

RTL_SRCS  := $(shell grep '^source/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
source/rd_pkg.sv
source/rd_arbiter.sv
source/axi_rd_master.sv
source/rd_data_align.sv
source/mem_read_top.sv
tb/axi_mem_model.sv
tb/tb_mem_read_top.sv

//--- source/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master #(
    parameter int ADDR_W = 32,
    parameter int ID_W   = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    // from arbiter
    input  logic                        start_i,
    input  logic [ADDR_W-1:0]           addr_i,
    input  rd_pkg::load_op_e            op_i,
    input  logic [ID_W-1:0]             id_i,
    output logic                        done_o,
    // ar channel
    output logic                        axi_ar_valid_o,
    input  logic                        axi_ar_ready_i,
    output logic [ADDR_W-1:0]           axi_ar_addr_o,
    output logic [ID_W-1:0]             axi_ar_id_o,
    output logic [7:0]                  axi_ar_len_o,
    output logic [2:0]                  axi_ar_size_o,
    output logic [1:0]                  axi_ar_burst_o,
    output logic [2:0]                  axi_ar_prot_o,
    output logic [3:0]                  axi_ar_cache_o,
    // r channel, rresp ignored
    input  logic                        axi_r_valid_i,
    output logic                        axi_r_ready_o,
    input  logic [rd_pkg::DATA_W-1:0]   axi_r_data_i,
    input  logic                        axi_r_last_i,
    input  logic [ID_W-1:0]             axi_r_id_i,
    // to alignment unit
    output logic                        beat_valid_o,
    output logic [rd_pkg::DATA_W-1:0]   beat_data_o,
    output logic                        beat_last_o,
    output logic [2:0]                  offset_o,
    output rd_pkg::load_op_e            op_o
);

    rd_pkg::rd_state_e state_q;
    rd_pkg::rd_state_e state_d;

    logic              ar_hs;
    logic              r_hs;
    logic [3:0]        span;      // bytes past the first one
    logic [3:0]        end_byte;
    logic              overstep;  // crosses the 8-byte boundary
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        len_q;
    logic [ID_W-1:0]   id_q;
    logic [2:0]        offset_q;
    rd_pkg::load_op_e  op_q;
    logic [7:0]        beat_cnt;

    assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
    assign r_hs  = axi_r_valid_i && axi_r_ready_o;

    always_comb begin
        case (op_i[1:0])
            2'b00:   span = 4'd0;
            2'b01:   span = 4'd1;
            2'b10:   span = 4'd3;
            default: span = 4'd7;
        endcase
    end

    assign end_byte = {1'b0, addr_i[2:0]} + span;
    assign overstep = end_byte[3];

    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_pkg::IDLE: if (start_i) state_d = rd_pkg::ADDR;
            rd_pkg::ADDR: if (ar_hs) state_d = rd_pkg::READ;
            rd_pkg::READ: if (r_hs && axi_r_last_i) state_d = rd_pkg::DONE;
            default:      state_d = rd_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= rd_pkg::IDLE;
            beat_cnt <= 8'd0;
        end else begin
            state_q <= state_d;
            if (state_q == rd_pkg::IDLE) begin
                beat_cnt <= 8'd0;
            end else if (r_hs) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
        end
    end

    // request fields captured at start
    always_ff @(posedge clk) begin
        if (state_q == rd_pkg::IDLE && start_i) begin
            addr_q   <= {addr_i[ADDR_W-1:3], 3'b000};  // 8-byte aligned
            len_q    <= {7'd0, overstep};
            id_q     <= id_i;
            offset_q <= addr_i[2:0];
            op_q     <= op_i;
        end
    end

    assign axi_ar_valid_o = (state_q == rd_pkg::ADDR);
    assign axi_ar_addr_o  = addr_q;
    assign axi_ar_id_o    = id_q;
    assign axi_ar_len_o   = len_q;
    assign axi_ar_size_o  = rd_pkg::AXI_SIZE_8B;
    assign axi_ar_burst_o = rd_pkg::AXI_BURST_INCR;
    assign axi_ar_prot_o  = rd_pkg::AXI_PROT_DATA;
    assign axi_ar_cache_o = rd_pkg::AXI_CACHE_NONCACHE;
    assign axi_r_ready_o  = (state_q == rd_pkg::READ);

    assign done_o       = (state_q == rd_pkg::DONE);
    assign beat_valid_o = r_hs;
    assign beat_data_o  = axi_r_data_i;
    assign beat_last_o  = axi_r_last_i;
    assign offset_o     = offset_q;
    assign op_o         = op_q;

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o)
    );

    a_r_id_match: assert property (
        @(posedge clk) disable iff (rst) r_hs |-> axi_r_id_i == id_q
    );

    a_r_last_count: assert property (
        @(posedge clk) disable iff (rst) r_hs |-> axi_r_last_i == (beat_cnt == len_q)
    );

endmodule

//--- source/mem_read_top.sv
`timescale 1ns/1ps

module mem_read_top #(
    parameter int ADDR_W = 32,
    parameter int ID_W   = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    // fetch port
    input  logic                        fetch_req_i,
    input  logic [ADDR_W-1:0]           fetch_addr_i,
    output logic                        fetch_valid_o,
    output logic [rd_pkg::DATA_W-1:0]   fetch_data_o,
    // load port
    input  logic                        load_req_i,
    input  logic [ADDR_W-1:0]           load_addr_i,
    input  rd_pkg::load_op_e            load_op_i,
    output logic                        load_valid_o,
    output logic [rd_pkg::DATA_W-1:0]   load_data_o,
    // ar channel
    output logic                        axi_ar_valid_o,
    input  logic                        axi_ar_ready_i,
    output logic [ADDR_W-1:0]           axi_ar_addr_o,
    output logic [ID_W-1:0]             axi_ar_id_o,
    output logic [7:0]                  axi_ar_len_o,
    output logic [2:0]                  axi_ar_size_o,
    output logic [1:0]                  axi_ar_burst_o,
    output logic [2:0]                  axi_ar_prot_o,
    output logic [3:0]                  axi_ar_cache_o,
    // r channel
    input  logic                        axi_r_valid_i,
    output logic                        axi_r_ready_o,
    input  logic [rd_pkg::DATA_W-1:0]   axi_r_data_i,
    input  logic                        axi_r_last_i,
    input  logic [ID_W-1:0]             axi_r_id_i
);

    logic                      start;
    logic [ADDR_W-1:0]         grant_addr;
    rd_pkg::load_op_e          grant_op;
    logic [ID_W-1:0]           grant_id;
    logic                      done;
    logic                      beat_valid;
    logic [rd_pkg::DATA_W-1:0] beat_data;
    logic                      beat_last;
    logic [2:0]                beat_offset;
    rd_pkg::load_op_e          beat_op;

    rd_arbiter #(
        .ADDR_W (ADDR_W),
        .ID_W   (ID_W)
    ) arb_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .load_req_i   (load_req_i),
        .load_addr_i  (load_addr_i),
        .load_op_i    (load_op_i),
        .done_i       (done),
        .start_o      (start),
        .addr_o       (grant_addr),
        .op_o         (grant_op),
        .id_o         (grant_id)
    );

    axi_rd_master #(
        .ADDR_W (ADDR_W),
        .ID_W   (ID_W)
    ) mst_i (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .addr_i         (grant_addr),
        .op_i           (grant_op),
        .id_i           (grant_id),
        .done_o         (done),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_id_o    (axi_ar_id_o),
        .axi_ar_len_o   (axi_ar_len_o),
        .axi_ar_size_o  (axi_ar_size_o),
        .axi_ar_burst_o (axi_ar_burst_o),
        .axi_ar_prot_o  (axi_ar_prot_o),
        .axi_ar_cache_o (axi_ar_cache_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_last_i   (axi_r_last_i),
        .axi_r_id_i     (axi_r_id_i),
        .beat_valid_o   (beat_valid),
        .beat_data_o    (beat_data),
        .beat_last_o    (beat_last),
        .offset_o       (beat_offset),
        .op_o           (beat_op)
    );

    // grant id stays put until done, so it names the result port
    rd_data_align #(
        .ID_W (ID_W)
    ) aln_i (
        .clk           (clk),
        .rst           (rst),
        .beat_valid_i  (beat_valid),
        .beat_data_i   (beat_data),
        .beat_last_i   (beat_last),
        .offset_i      (beat_offset),
        .op_i          (beat_op),
        .id_i          (grant_id),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .load_valid_o  (load_valid_o),
        .load_data_o   (load_data_o)
    );

endmodule

//--- source/rd_arbiter.sv
`timescale 1ns/1ps

module rd_arbiter #(
    parameter int ADDR_W = 32,
    parameter int ID_W   = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    // fetch requester
    input  logic                 fetch_req_i,
    input  logic [ADDR_W-1:0]    fetch_addr_i,
    // load requester
    input  logic                 load_req_i,
    input  logic [ADDR_W-1:0]    load_addr_i,
    input  rd_pkg::load_op_e     load_op_i,
    // from read master
    input  logic                 done_i,
    // to read master
    output logic                 start_o,
    output logic [ADDR_W-1:0]    addr_o,
    output rd_pkg::load_op_e     op_o,
    output logic [ID_W-1:0]      id_o
);

    logic busy_q;
    logic done_q;       // one cycle holdoff after done
    logic last_load_q;  // load won the last contested grant
    logic both_req;
    logic pick_load;
    logic grant;

    assign both_req  = fetch_req_i && load_req_i;
    assign pick_load = both_req ? !last_load_q : load_req_i;

    // requester still holds req in the cycle after its valid
    assign grant = !busy_q && !done_q && (fetch_req_i || load_req_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            last_load_q <= 1'b0;  // load goes first after reset
            start_o     <= 1'b0;
        end else begin
            start_o <= grant;
            done_q  <= done_i;
            if (grant) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
            // priority only flips on a contested grant
            if (grant && both_req) begin
                last_load_q <= pick_load;
            end
        end
    end

    // granted request, held until the next grant
    always_ff @(posedge clk) begin
        if (grant) begin
            addr_o <= pick_load ? load_addr_i : fetch_addr_i;
            op_o   <= pick_load ? load_op_i : rd_pkg::LWU;  // fetch is a 32-bit word
            id_o   <= ID_W'(pick_load);                     // fetch 0, load 1
        end
    end

    // master only finishes a granted transaction
    a_done_while_busy: assert property (
        @(posedge clk) disable iff (rst) done_i |-> busy_q
    );

endmodule

//--- source/rd_data_align.sv
`timescale 1ns/1ps

module rd_data_align #(
    parameter int ID_W = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    // beats from read master
    input  logic                        beat_valid_i,
    input  logic [rd_pkg::DATA_W-1:0]   beat_data_i,
    input  logic                        beat_last_i,
    input  logic [2:0]                  offset_i,
    input  rd_pkg::load_op_e            op_i,
    input  logic [ID_W-1:0]             id_i,
    // results
    output logic                        fetch_valid_o,
    output logic [rd_pkg::DATA_W-1:0]   fetch_data_o,
    output logic                        load_valid_o,
    output logic [rd_pkg::DATA_W-1:0]   load_data_o
);

    logic                        have_first;  // low half already captured
    logic [rd_pkg::DATA_W-1:0]   low_q;
    logic [2*rd_pkg::DATA_W-1:0] window;
    logic [2*rd_pkg::DATA_W-1:0] shifted;
    logic [rd_pkg::DATA_W-1:0]   val;
    logic [rd_pkg::DATA_W-1:0]   ext;
    logic [rd_pkg::DATA_W-1:0]   result_q;
    logic                        is_fetch;

    // second beat goes above the first, single beat stands alone
    assign window  = have_first ? {beat_data_i, low_q}
                                : {{rd_pkg::DATA_W{1'b0}}, beat_data_i};
    assign shifted = window >> {offset_i, 3'b000};
    assign val     = shifted[rd_pkg::DATA_W-1:0];

    always_comb begin
        case (op_i)
            rd_pkg::LB:  ext = {{56{val[7]}}, val[7:0]};
            rd_pkg::LH:  ext = {{48{val[15]}}, val[15:0]};
            rd_pkg::LW:  ext = {{32{val[31]}}, val[31:0]};
            rd_pkg::LBU: ext = {56'd0, val[7:0]};
            rd_pkg::LHU: ext = {48'd0, val[15:0]};
            rd_pkg::LWU: ext = {32'd0, val[31:0]};
            default:     ext = val;  // LD
        endcase
    end

    assign is_fetch = (id_i == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            have_first    <= 1'b0;
            fetch_valid_o <= 1'b0;
            load_valid_o  <= 1'b0;
        end else begin
            fetch_valid_o <= beat_valid_i && beat_last_i && is_fetch;
            load_valid_o  <= beat_valid_i && beat_last_i && !is_fetch;
            if (beat_valid_i) begin
                have_first <= !beat_last_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i && !beat_last_i) begin
            low_q <= beat_data_i;
        end
        if (beat_valid_i && beat_last_i) begin
            result_q <= ext;
        end
    end

    // both ports see the result, only the named one gets valid
    assign fetch_data_o = result_q;
    assign load_data_o  = result_q;

endmodule

//--- source/rd_pkg.sv
package rd_pkg;

    // result and AXI data width
    localparam int DATA_W = 64;

    // bit 2 set means zero extension, bits 1:0 give the size
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } load_op_e;

    // read master states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        READ = 2'b10,
        DONE = 2'b11
    } rd_state_e;

    // 8 bytes per beat
    localparam logic [2:0] AXI_SIZE_8B = 3'b011;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // unprivileged, secure, data access
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;

    // non-cacheable, non-bufferable
    localparam logic [3:0] AXI_CACHE_NONCACHE = 4'b0000;

endpackage

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int ADDR_W = 32,
    parameter int ID_W   = 4,
    parameter int SEED   = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              delay_en_i,  // random AR and R stalls
    // ar channel
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    input  logic [ADDR_W-1:0] ar_addr_i,
    input  logic [ID_W-1:0]   ar_id_i,
    input  logic [7:0]        ar_len_i,
    // r channel
    output logic              r_valid_o,
    input  logic              r_ready_i,
    output logic [63:0]       r_data_o,
    output logic              r_last_o,
    output logic [ID_W-1:0]   r_id_o
);

    integer            seed;
    logic              busy;      // burst accepted, beats pending
    logic [ADDR_W-1:0] base_q;
    logic [7:0]        len_q;
    logic [7:0]        beat_q;
    int                wait_cnt;

    initial begin
        seed       = SEED;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_last_o   = 1'b0;
        r_id_o     = '0;
    end

    // memory content is a pure function of the address
    function automatic logic [7:0] pattern_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic logic [63:0] beat_word(input logic [ADDR_W-1:0] a);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) begin
            w[8*b +: 8] = pattern_byte(a + ADDR_W'(b));
        end
        return w;
    endfunction

    function int next_delay();
        if (!delay_en_i) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % 4);  // 0 to 3 idle cycles
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_last_o   <= 1'b0;
            busy       <= 1'b0;
            wait_cnt   <= 0;
        end else if (!busy) begin
            if (ar_valid_i && ar_ready_o) begin
                ar_ready_o <= 1'b0;
                busy       <= 1'b1;
                base_q     <= ar_addr_i;
                len_q      <= ar_len_i;
                r_id_o     <= ar_id_i;
                beat_q     <= 8'd0;
                wait_cnt   <= next_delay();
            end else if (ar_valid_i) begin
                if (wait_cnt == 0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end else if (r_valid_o && r_ready_i) begin
            r_valid_o <= 1'b0;
            beat_q    <= beat_q + 8'd1;
            wait_cnt  <= next_delay();
            if (r_last_o) begin
                busy <= 1'b0;
            end
        end else if (!r_valid_o) begin
            if (wait_cnt == 0) begin
                r_valid_o <= 1'b1;
                r_data_o  <= beat_word(base_q + ADDR_W'({beat_q, 3'b000}));  // incr by 8
                r_last_o  <= (beat_q == len_q);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

//--- tb/tb_mem_read_top.sv
`timescale 1ns/1ps

module tb_mem_read_top;

    localparam int ADDR_W     = 32;
    localparam int ID_W       = 4;
    localparam int NUM_ROWS   = 16;
    localparam int ROW_LIMIT  = 100;  // cycles per row
    localparam int PORT_FETCH = 0;
    localparam int PORT_LOAD  = 1;
    localparam int PORT_PAIR  = 2;

    logic                      clk;
    logic                      rst;
    logic                      fetch_req;
    logic [ADDR_W-1:0]         fetch_addr;
    logic                      fetch_valid;
    logic [rd_pkg::DATA_W-1:0] fetch_data;
    logic                      load_req;
    logic [ADDR_W-1:0]         load_addr;
    rd_pkg::load_op_e          load_op;
    logic                      load_valid;
    logic [rd_pkg::DATA_W-1:0] load_data;
    logic                      mem_delay_en;
    logic                      ar_valid;
    logic                      ar_ready;
    logic [ADDR_W-1:0]         ar_addr;
    logic [ID_W-1:0]           ar_id;
    logic [7:0]                ar_len;
    logic [2:0]                ar_size;
    logic [1:0]                ar_burst;
    logic [2:0]                ar_prot;
    logic [3:0]                ar_cache;
    logic                      r_valid;
    logic                      r_ready;
    logic [rd_pkg::DATA_W-1:0] r_data;
    logic                      r_last;
    logic [ID_W-1:0]           r_id;

    // stimulus table, load side and fetch side per row
    string                     row_name       [NUM_ROWS];
    int                        row_port       [NUM_ROWS];
    logic [ADDR_W-1:0]         row_addr       [NUM_ROWS];
    rd_pkg::load_op_e          row_op         [NUM_ROWS];
    logic [rd_pkg::DATA_W-1:0] row_exp        [NUM_ROWS];
    logic [ADDR_W-1:0]         row_faddr      [NUM_ROWS];
    logic [rd_pkg::DATA_W-1:0] row_fexp       [NUM_ROWS];
    bit                        row_load_first [NUM_ROWS];
    bit                        row_slow       [NUM_ROWS];
    int                        row_cnt;
    int                        errors;
    int                        checks;

    mem_read_top #(
        .ADDR_W (ADDR_W),
        .ID_W   (ID_W)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .fetch_valid_o  (fetch_valid),
        .fetch_data_o   (fetch_data),
        .load_req_i     (load_req),
        .load_addr_i    (load_addr),
        .load_op_i      (load_op),
        .load_valid_o   (load_valid),
        .load_data_o    (load_data),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_id_o    (ar_id),
        .axi_ar_len_o   (ar_len),
        .axi_ar_size_o  (ar_size),
        .axi_ar_burst_o (ar_burst),
        .axi_ar_prot_o  (ar_prot),
        .axi_ar_cache_o (ar_cache),
        .axi_r_valid_i  (r_valid),
        .axi_r_ready_o  (r_ready),
        .axi_r_data_i   (r_data),
        .axi_r_last_i   (r_last),
        .axi_r_id_i     (r_id)
    );

    axi_mem_model #(
        .ADDR_W (ADDR_W),
        .ID_W   (ID_W),
        .SEED   (7294)
    ) mem_i (
        .clk        (clk),
        .rst        (rst),
        .delay_en_i (mem_delay_en),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .ar_id_i    (ar_id),
        .ar_len_i   (ar_len),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .r_last_o   (r_last),
        .r_id_o     (r_id)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // little endian bytes, then sign or zero fill by opcode
    function automatic logic [63:0] expect_value(input logic [ADDR_W-1:0] addr,
                                                 input rd_pkg::load_op_e op);
        int          nbytes;
        int          i;
        bit          sext;
        logic [63:0] v;
        case (op)
            rd_pkg::LB, rd_pkg::LBU: nbytes = 1;
            rd_pkg::LH, rd_pkg::LHU: nbytes = 2;
            rd_pkg::LW, rd_pkg::LWU: nbytes = 4;
            default:                 nbytes = 8;
        endcase
        sext = (op == rd_pkg::LB) || (op == rd_pkg::LH) || (op == rd_pkg::LW);
        v = '0;
        for (i = 0; i < nbytes; i++) begin
            v[8*i +: 8] = mem_byte(addr + ADDR_W'(i));
        end
        if (sext && v[8*nbytes-1]) begin
            for (i = nbytes; i < 8; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic add_row(input string name, input int port, input logic [ADDR_W-1:0] addr,
                           input rd_pkg::load_op_e op, input logic [ADDR_W-1:0] faddr,
                           input bit load_first, input bit slow);
        row_name[row_cnt]       = name;
        row_port[row_cnt]       = port;
        row_addr[row_cnt]       = addr;
        row_op[row_cnt]         = op;
        row_exp[row_cnt]        = expect_value(addr, op);
        row_faddr[row_cnt]      = faddr;
        row_fexp[row_cnt]       = expect_value(faddr, rd_pkg::LWU);  // fetch word
        row_load_first[row_cnt] = load_first;
        row_slow[row_cnt]       = slow;
        row_cnt++;
    endtask

    task automatic build_table();
        add_row("lb_neg",        PORT_LOAD,  32'h0080, rd_pkg::LB,  '0, 0, 0);
        add_row("lbu_neg",       PORT_LOAD,  32'h0088, rd_pkg::LBU, '0, 0, 0);
        add_row("lb_pos",        PORT_LOAD,  32'h1234, rd_pkg::LB,  '0, 0, 0);
        add_row("lh_neg",        PORT_LOAD,  32'h00f0, rd_pkg::LH,  '0, 0, 0);
        add_row("lhu_neg",       PORT_LOAD,  32'h00f2, rd_pkg::LHU, '0, 0, 0);
        add_row("lw_neg",        PORT_LOAD,  32'h00c4, rd_pkg::LW,  '0, 0, 0);
        add_row("lwu_neg",       PORT_LOAD,  32'h3394, rd_pkg::LWU, '0, 0, 0);
        add_row("ld",            PORT_LOAD,  32'h0208, rd_pkg::LD,  '0, 0, 0);
        add_row("lw_cross",      PORT_LOAD,  32'h0106, rd_pkg::LW,  '0, 0, 0);  // offset 6
        add_row("ld_cross",      PORT_LOAD,  32'h0a53, rd_pkg::LD,  '0, 0, 0);  // offset 3
        add_row("fetch",         PORT_FETCH, '0,       rd_pkg::LWU, 32'h00e0, 0, 0);
        // first contested grant goes to load, the next one to fetch
        add_row("pair_load_1st", PORT_PAIR,  32'h0510, rd_pkg::LD,  32'h0f84, 1, 0);
        add_row("pair_fetch_1st", PORT_PAIR, 32'h0628, rd_pkg::LW,  32'h0744, 0, 0);
        add_row("slow_lh_cross", PORT_LOAD,  32'h014f, rd_pkg::LH,  '0, 0, 1);
        add_row("slow_fetch",    PORT_FETCH, '0,       rd_pkg::LWU, 32'h2200, 0, 1);
        add_row("slow_pair",     PORT_PAIR,  32'h01f5, rd_pkg::LD,  32'h0c0c, 1, 1);
    endtask

    task automatic run_row(input int idx);
        bit fetch_on;
        bit load_on;
        bit fetch_seen;
        bit load_seen;
        bit load_won;  // load result came before fetch
        int cycles;
        fetch_on   = (row_port[idx] != PORT_LOAD);
        load_on    = (row_port[idx] != PORT_FETCH);
        fetch_seen = 1'b0;
        load_seen  = 1'b0;
        load_won   = 1'b0;
        cycles     = 0;
        @(posedge clk);
        mem_delay_en <= row_slow[idx];
        if (fetch_on) begin
            fetch_req  <= 1'b1;
            fetch_addr <= row_faddr[idx];
        end
        if (load_on) begin
            load_req  <= 1'b1;
            load_addr <= row_addr[idx];
            load_op   <= row_op[idx];
        end
        while (((fetch_on && !fetch_seen) || (load_on && !load_seen)) && cycles < ROW_LIMIT) begin
            @(negedge clk);
            cycles++;
            // 8-byte INCR beats, unprivileged secure data, non-cacheable
            if (ar_valid) begin
                checks++;
                assert (ar_size == 3'd3 && ar_burst == 2'b01 && ar_prot == 3'b000
                        && ar_cache == 4'b0000) else begin
                    $display("error: %s ar size burst prot cache expected %h actual %h",
                             row_name[idx], {3'd3, 2'b01, 3'b000, 4'b0000},
                             {ar_size, ar_burst, ar_prot, ar_cache});
                    errors++;
                end
            end
            if (fetch_valid) begin
                checks++;
                assert (fetch_on && !fetch_seen) else begin
                    $display("%s: fetch_valid_o pulsed with no fetch open", row_name[idx]);
                    errors++;
                end
                assert (!fetch_on || fetch_data == row_fexp[idx]) else begin
                    $display("error: %s fetch expected %h actual %h",
                             row_name[idx], row_fexp[idx], fetch_data);
                    errors++;
                end
                fetch_seen = 1'b1;
            end
            if (load_valid) begin
                checks++;
                assert (load_on && !load_seen) else begin
                    $display("%s: load_valid_o pulsed with no load open", row_name[idx]);
                    errors++;
                end
                assert (!load_on || load_data == row_exp[idx]) else begin
                    $display("error: %s load expected %h actual %h",
                             row_name[idx], row_exp[idx], load_data);
                    errors++;
                end
                load_won  = !fetch_seen;
                load_seen = 1'b1;
            end
            @(posedge clk);
            if (fetch_seen) begin
                fetch_req <= 1'b0;
            end
            if (load_seen) begin
                load_req <= 1'b0;
            end
        end
        checks++;
        assert ((!fetch_on || fetch_seen) && (!load_on || load_seen)) else begin
            $display("%s: no result within %0d cycles", row_name[idx], ROW_LIMIT);
            errors++;
        end
        if (row_port[idx] == PORT_PAIR) begin
            checks++;
            assert (load_won == row_load_first[idx]) else begin
                $display("error: %s load first expected %0d actual %0d",
                         row_name[idx], row_load_first[idx], load_won);
                errors++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        load_req     = 1'b0;
        load_addr    = '0;
        load_op      = rd_pkg::LB;
        mem_delay_en = 1'b0;
        errors       = 0;
        checks       = 0;
        row_cnt      = 0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!fetch_valid && !load_valid && !ar_valid && !r_ready) else begin
            $display("a result valid, arvalid or rready is high right after reset");
            errors++;
        end
        for (int i = 0; i < row_cnt; i++) begin
            run_row(i);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // budget of 200 cycles per table row
    initial begin
        repeat (NUM_ROWS * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", NUM_ROWS * 200);
        $display("tests failed");
        $finish;
    end

endmodule
